// File: lookup_engine.f
verilog/lookup_pkg.sv
verilog/ctrl_pkg.sv
verilog/ctrl_parser.sv
verilog/entry_assembler.sv
verilog/match_cam.sv
verilog/action_ram.sv
verilog/lookup_ctrl.sv
verilog/lookup_engine.sv
verif/tb_lookup_engine.sv

// File: run_sim.sh
#!/bin/sh
# builds the lookup engine testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module tb_lookup_engine -f lookup_engine.f -o sim_lookup_engine || exit 1
out=$(./obj_dir/sim_lookup_engine)
echo "$out"
echo "$out" | grep -q "ALL CHECKS PASSED" && exit 0 || exit 1

// File: verif/tb_lookup_engine.sv
// testbench for the lookup stage, walks a table of table writes, foreign packets and lookups
`timescale 1ns/1ns
`default_nettype none

module tb_lookup_engine;

    localparam logic [4:0]   stage_id       = 5'd9;
    localparam logic [2:0]   lookup_id      = 3'd2;
    localparam logic [15:0]  magic          = 16'hf2f1;
    localparam logic [127:0] miss_action    = 128'h3f;
    localparam int           lookup_timeout = 20;

    // row operations
    localparam int op_cam     = 0;
    localparam int op_act     = 1;
    localparam int op_foreign = 2;
    localparam int op_lookup  = 3;

    logic                 clk = 1'b0;
    logic                 rst_n;
    lookup_pkg::key_t     key;
    lookup_pkg::key_t     mask;
    logic                 key_valid;
    lookup_pkg::phv_t     phv_in;
    lookup_pkg::action_t  action;
    logic                 action_valid;
    lookup_pkg::phv_t     phv_out;
    ctrl_pkg::ctrl_data_t c_s_tdata;
    logic                 c_s_tvalid;
    logic                 c_s_tlast;
    ctrl_pkg::ctrl_data_t c_m_tdata;
    logic                 c_m_tvalid;
    logic                 c_m_tlast;

    integer seed;
    int     errors;
    int     checks;

    // stimulus table, one entry per row in each queue
    int               row_op   [$];
    int               row_idx  [$];
    int               row_cnt  [$];
    lookup_pkg::key_t row_key  [$];
    lookup_pkg::key_t row_mask [$];
    logic [127:0]     row_data [$];
    int               row_exp  [$];

    // reference model of the tables and of the c_m output
    lookup_pkg::key_t model_key [16];
    logic [127:0]     model_act [16];
    logic [15:0]      model_valid;
    logic [63:0]      pkt_q [$];
    logic [65:0]      fwd_q [$];

    lookup_engine #(
        .stage_id  (stage_id),
        .lookup_id (lookup_id)
    ) UUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .key          (key),
        .mask         (mask),
        .key_valid    (key_valid),
        .phv_in       (phv_in),
        .action       (action),
        .action_valid (action_valid),
        .phv_out      (phv_out),
        .c_s_tdata    (c_s_tdata),
        .c_s_tvalid   (c_s_tvalid),
        .c_s_tlast    (c_s_tlast),
        .c_m_tdata    (c_m_tdata),
        .c_m_tvalid   (c_m_tvalid),
        .c_m_tlast    (c_m_tlast)
    );

    always #50 clk = ~clk;

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic add_row(input int op, input int idx, input int cnt, input logic [23:0] k,
                           input logic [23:0] m, input logic [127:0] d, input int e);
        row_op.push_back(op);
        row_idx.push_back(idx);
        row_cnt.push_back(cnt);
        row_key.push_back(k);
        row_mask.push_back(m);
        row_data.push_back(d);
        row_exp.push_back(e);
    endtask

    // wire order is little endian
    function automatic logic [63:0] swap_bytes(input logic [63:0] d);
        swap_bytes = {d[7:0], d[15:8], d[23:16], d[31:24],
                      d[39:32], d[47:40], d[55:48], d[63:56]};
    endfunction

    function automatic logic [63:0] make_header(input logic [4:0] stg, input logic [2:0] lkp,
                                                input logic [15:0] flag, input logic [3:0] kind,
                                                input logic [7:0] idx);
        make_header = {24'h0, idx, 4'h0, kind, stg, lkp, flag};
    endfunction

    // lowest valid index whose unmasked bits agree, -1 on a miss
    function automatic int search_model(input lookup_pkg::key_t k, input lookup_pkg::key_t m);
        int i;
        search_model = -1;
        for (i = 0; i < 16; i++) begin
            if ((search_model < 0) && model_valid[i] && (((model_key[i] ^ k) & ~m) == 24'h0)) begin
                search_model = i;
            end
        end
    endfunction

    task automatic check_forward();
        logic [65:0] e;
        e = fwd_q.pop_front();
        check_value("c_m_tvalid", 128'(c_m_tvalid), 128'(e[65]));
        check_value("c_m_tlast", 128'(c_m_tlast), 128'(e[64]));
        if (e[65]) begin
            check_value("c_m_tdata", 128'(c_m_tdata), 128'(e[63:0]));
        end
    endtask

    // drives pkt_q one beat per cycle, c_m must follow one cycle later when forwarded
    task automatic send_packet(input bit fwd);
        int i;
        fwd_q.delete();
        for (i = 0; i < pkt_q.size(); i++) begin
            @(negedge clk);
            if (fwd_q.size() > 0) begin
                check_forward();
            end
            c_s_tdata  = pkt_q[i];
            c_s_tvalid = 1'b1;
            c_s_tlast  = (i == pkt_q.size() - 1);
            fwd_q.push_back({fwd, c_s_tlast & fwd, fwd ? pkt_q[i] : 64'h0});
        end
        @(negedge clk);
        c_s_tdata  = '0;
        c_s_tvalid = 1'b0;
        c_s_tlast  = 1'b0;
        check_forward();
        @(negedge clk);
        check_value("c_m_tvalid", 128'(c_m_tvalid), 128'd0);
    endtask

    task automatic write_cam(input int idx, input int cnt, input lookup_pkg::key_t base);
        int j;
        lookup_pkg::key_t k;
        pkt_q.delete();
        pkt_q.push_back(make_header(stage_id, lookup_id, magic, 4'h0, 8'(idx)));
        for (j = 0; j < cnt; j++) begin
            k = base + 24'(j);
            pkt_q.push_back(swap_bytes({k, 40'h0}));
            model_key[4'(idx + j)]   = k;
            model_valid[4'(idx + j)] = 1'b1;
        end
        send_packet(1'b0);
    endtask

    // two beats per action, upper half first
    task automatic write_actions(input int idx, input int cnt, input logic [127:0] base);
        int j;
        logic [127:0] a;
        pkt_q.delete();
        pkt_q.push_back(make_header(stage_id, lookup_id, magic, 4'h1, 8'(idx)));
        for (j = 0; j < cnt; j++) begin
            a = base + 128'(j);
            pkt_q.push_back(swap_bytes(a[127:64]));
            pkt_q.push_back(swap_bytes(a[63:0]));
            model_act[4'(idx + j)] = a;
        end
        send_packet(1'b0);
    endtask

    // variant 0 wrong stage, 1 wrong lookup, 2 wrong magic
    task automatic send_foreign(input int variant, input int cnt, input logic [63:0] base);
        logic [63:0] hdr;
        int j;
        case (variant)
            0: hdr = make_header(stage_id + 5'd1, lookup_id, magic, 4'h0, 8'h0);
            1: hdr = make_header(stage_id, lookup_id + 3'd1, magic, 4'h0, 8'h0);
            default: hdr = make_header(stage_id, lookup_id, magic ^ 16'h0001, 4'h0, 8'h0);
        endcase
        pkt_q.delete();
        pkt_q.push_back(hdr);
        for (j = 0; j < cnt; j++) begin
            pkt_q.push_back(base + 64'(j));
        end
        send_packet(1'b1);
    endtask

    task automatic run_lookup(input lookup_pkg::key_t k, input lookup_pkg::key_t m,
                              input int exp_row);
        lookup_pkg::key_t kk;
        lookup_pkg::phv_t phv;
        logic [127:0]     exp_act;
        int               hit_idx;
        int               lat;
        bit               seen;
        kk = k;
        // miss rows get random low key bits
        if (exp_row < 0) begin
            kk[15:0] = 16'($random(seed));
        end
        phv     = {$random(seed), $random(seed)};
        hit_idx = search_model(kk, m);
        check_value("expected_index", 128'(hit_idx), 128'(exp_row));
        if (hit_idx < 0) begin
            exp_act = miss_action;
        end else begin
            exp_act = model_act[4'(hit_idx)];
        end
        @(negedge clk);
        key       = kk;
        mask      = m;
        phv_in    = phv;
        key_valid = 1'b1;
        @(negedge clk);
        key_valid = 1'b0;
        lat  = 0;
        seen = 1'b0;
        while (!seen && (lat < lookup_timeout)) begin
            @(negedge clk);
            lat++;
            seen = action_valid;
        end
        if (!seen) begin
            errors++;
            $display("timeout: no action_valid after lookup of key %h", kk);
        end else begin
            check_value("latency", 128'(lat), (hit_idx < 0) ? 128'd1 : 128'd3);
            check_value("action", action, exp_act);
            check_value("phv_out", 128'(phv_out), 128'(phv));
            @(negedge clk);
            check_value("action_valid", 128'(action_valid), 128'd0);
        end
    endtask

    task automatic build_table();
        add_row(op_lookup, 0, 0, 24'hee0000, 24'h0, 128'h0, -1);
        add_row(op_cam, 3, 1, 24'h123456, 24'h0, 128'h0, 0);
        add_row(op_act, 3, 1, 24'h0, 24'h0, 128'h0123_4567_89ab_cdef_fedc_ba98_7654_3210, 0);
        add_row(op_lookup, 0, 0, 24'h123456, 24'h0, 128'h0, 3);
        add_row(op_cam, 5, 1, 24'h12ab56, 24'h0, 128'h0, 0);
        add_row(op_act, 5, 1, 24'h0, 24'h0, 128'h5555_aaaa_0000_ffff_1234_4321_a5a5_5a5a, 0);
        // both 3 and 5 match under this mask
        add_row(op_lookup, 0, 0, 24'h12cd56, 24'h00ff00, 128'h0, 3);
        add_row(op_lookup, 0, 0, 24'h12ab56, 24'h0, 128'h0, 5);
        add_row(op_lookup, 0, 0, 24'h12ab57, 24'h000001, 128'h0, 5);
        add_row(op_cam, 8, 3, 24'ha00001, 24'h0, 128'h0, 0);
        add_row(op_act, 8, 3, 24'h0, 24'h0, 128'hc0de_0000_1111_2222_3333_4444_5555_0100, 0);
        add_row(op_lookup, 0, 0, 24'ha00001, 24'h0, 128'h0, 8);
        add_row(op_lookup, 0, 0, 24'ha00002, 24'h0, 128'h0, 9);
        add_row(op_lookup, 0, 0, 24'ha00003, 24'h0, 128'h0, 10);
        add_row(op_foreign, 0, 2, 24'h0, 24'h0, 128'h1000_0000_0000_0a00, 0);
        add_row(op_foreign, 1, 1, 24'h0, 24'h0, 128'h2000_0000_0000_0b00, 0);
        add_row(op_foreign, 2, 3, 24'h0, 24'h0, 128'h3000_0000_0000_0c00, 0);
        add_row(op_lookup, 0, 0, 24'hee0000, 24'h0, 128'h0, -1);
        add_row(op_lookup, 0, 0, 24'h123456, 24'h0, 128'h0, 3);
    endtask

    initial begin
        int r;
        seed        = 70667;
        errors      = 0;
        checks      = 0;
        model_valid = '0;
        rst_n       = 1'b0;
        key         = '0;
        mask        = '0;
        key_valid   = 1'b0;
        phv_in      = '0;
        c_s_tdata   = '0;
        c_s_tvalid  = 1'b0;
        c_s_tlast   = 1'b0;
        build_table();
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        check_value("action_valid", 128'(action_valid), 128'd0);
        check_value("c_m_tvalid", 128'(c_m_tvalid), 128'd0);
        for (r = 0; r < row_op.size(); r++) begin
            case (row_op[r])
                op_cam:     write_cam(row_idx[r], row_cnt[r], row_key[r]);
                op_act:     write_actions(row_idx[r], row_cnt[r], row_data[r]);
                op_foreign: send_foreign(row_idx[r], row_cnt[r], row_data[r][63:0]);
                default:    run_lookup(row_key[r], row_mask[r], row_exp[r]);
            endcase
        end
        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/action_ram.sv
// action memory, written from the control path and read at the cam match address
`timescale 1ns/1ns
`default_nettype none

module action_ram (
    input  logic                clk,
    input  logic                wr_en,
    input  lookup_pkg::index_t  wr_index,
    input  lookup_pkg::action_t wr_action,
    input  lookup_pkg::index_t  rd_index,
    output lookup_pkg::action_t rd_action
);

    lookup_pkg::action_t mem [lookup_pkg::table_depth];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_index] <= wr_action;
        end
    end

    // one cycle behind rd_index
    always_ff @(posedge clk) begin
        rd_action <= mem[rd_index];
    end

endmodule

`default_nettype wire

// File: verilog/ctrl_parser.sv
// control header decoder that steers table-write packets to the assemblers and forwards the rest
`timescale 1ns/1ns
`default_nettype none

module ctrl_parser #(
    parameter logic [4:0] stage_id  = 5'd0,
    parameter logic [2:0] lookup_id = 3'd0
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  ctrl_pkg::ctrl_data_t c_s_tdata,
    input  logic                 c_s_tvalid,
    input  logic                 c_s_tlast,
    output ctrl_pkg::ctrl_data_t c_m_tdata,
    output logic                 c_m_tvalid,
    output logic                 c_m_tlast,
    output logic                 cam_start,
    output logic                 act_start,
    output lookup_pkg::index_t   start_index,
    output logic                 cam_beat_valid,
    output logic                 act_beat_valid,
    output ctrl_pkg::ctrl_data_t beat_data
);

    typedef enum logic [1:0] {
        idle,
        cam_payload,
        act_payload,
        forward
    } state_t;

    state_t state;

    logic [ctrl_pkg::flag_width-1:0]   control_flag;
    logic [ctrl_pkg::mod_id_width-1:0] mod_id;
    logic [ctrl_pkg::kind_width-1:0]   kind;
    logic                              for_us;
    logic                              header_beat;
    logic                              fwd_beat;

    // header fields, only meaningful on the first beat
    assign control_flag = c_s_tdata[ctrl_pkg::flag_lsb +: ctrl_pkg::flag_width];
    assign mod_id       = c_s_tdata[ctrl_pkg::mod_id_lsb +: ctrl_pkg::mod_id_width];
    assign kind         = c_s_tdata[ctrl_pkg::kind_lsb +: ctrl_pkg::kind_width];

    // stage number in the upper 5 bits, lookup number in the lower 3
    assign for_us = (mod_id[7:3] == stage_id) && (mod_id[2:0] == lookup_id) &&
                    (control_flag == ctrl_pkg::ctrl_magic);

    assign header_beat = (state == idle) && c_s_tvalid;

    assign cam_start   = header_beat && for_us && (kind == ctrl_pkg::kind_cam);
    assign act_start   = header_beat && for_us && (kind != ctrl_pkg::kind_cam);
    assign start_index = lookup_pkg::index_t'(
        c_s_tdata[ctrl_pkg::index_lsb +: ctrl_pkg::index_field_width]);

    // payload beats go straight to the assemblers, which register them
    assign cam_beat_valid = (state == cam_payload) && c_s_tvalid;
    assign act_beat_valid = (state == act_payload) && c_s_tvalid;
    assign beat_data      = c_s_tdata;

    // a foreign packet's first beat is forwarded too
    assign fwd_beat = c_s_tvalid && (((state == idle) && !for_us) || (state == forward));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= idle;
            c_m_tvalid <= 1'b0;
            c_m_tlast  <= 1'b0;
        end else begin
            c_m_tvalid <= fwd_beat;
            c_m_tlast  <= fwd_beat && c_s_tlast;
            case (state)
                idle: begin
                    // single-beat packets never leave idle
                    if (c_s_tvalid && !c_s_tlast) begin
                        if (!for_us) begin
                            state <= forward;
                        end else if (kind == ctrl_pkg::kind_cam) begin
                            state <= cam_payload;
                        end else begin
                            state <= act_payload;
                        end
                    end
                end
                default: begin
                    if (c_s_tvalid && c_s_tlast) begin
                        state <= idle;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (fwd_beat) begin
            c_m_tdata <= c_s_tdata;
        end
    end

    // header index must fit the table, the upper bits would be dropped silently
    a_index_in_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        (cam_start || act_start) |->
            (c_s_tdata[ctrl_pkg::index_lsb + lookup_pkg::index_width +:
                       (ctrl_pkg::index_field_width - lookup_pkg::index_width)] == '0)
    ) else $error("control header index exceeds table depth");

endmodule

`default_nettype wire

// File: verilog/ctrl_pkg.sv
// control-stream beat layout and header encodings shared by the control path modules
`default_nettype none

package ctrl_pkg;

    localparam int ctrl_width = 64;

    typedef logic [ctrl_width-1:0] ctrl_data_t;

    // header fields, all in the first beat
    localparam int flag_lsb          = 0;
    localparam int flag_width        = 16;
    localparam int mod_id_lsb        = 16;
    localparam int mod_id_width      = 8;
    localparam int kind_lsb          = 24;
    localparam int kind_width        = 4;
    localparam int index_lsb         = 32;
    localparam int index_field_width = 8;

    // control_flag value that marks a table write
    localparam logic [flag_width-1:0] ctrl_magic = 16'hf2f1;

    // anything other than kind_cam loads the action memory
    localparam logic [kind_width-1:0] kind_cam = 4'h0;

endpackage

`default_nettype wire

// File: verilog/entry_assembler.sv
// builds cam keys or action entries from byte-reversed control beats, one write per entry
`timescale 1ns/1ns
`default_nettype none

module entry_assembler #(
    parameter type entry_t = lookup_pkg::key_t
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start,
    input  lookup_pkg::index_t   start_index,
    input  logic                 beat_valid,
    input  ctrl_pkg::ctrl_data_t beat_data,
    output logic                 wr_en,
    output lookup_pkg::index_t   wr_index,
    output entry_t               wr_entry
);

    localparam int entry_width = $bits(entry_t);
    localparam int beats       = (entry_width + ctrl_pkg::ctrl_width - 1) / ctrl_pkg::ctrl_width;
    localparam int acc_width   = beats * ctrl_pkg::ctrl_width;

    ctrl_pkg::ctrl_data_t swapped;
    logic [acc_width-1:0] acc_q;
    logic [acc_width-1:0] acc_next;
    logic [3:0]           beat_cnt;
    logic                 last_beat;
    lookup_pkg::index_t   next_index;

    // little endian on the wire, big endian in the tables
    always_comb begin
        for (int i = 0; i < ctrl_pkg::ctrl_width / 8; i++) begin
            swapped[8*i +: 8] = beat_data[ctrl_pkg::ctrl_width - 8 - 8*i +: 8];
        end
    end

    // first beat ends up in the most significant part
    always_comb begin
        acc_next = acc_q << ctrl_pkg::ctrl_width;
        acc_next[ctrl_pkg::ctrl_width-1:0] = swapped;
    end

    assign last_beat = beat_valid && (beat_cnt == 4'(beats - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_cnt   <= '0;
            wr_en      <= 1'b0;
            next_index <= '0;
        end else begin
            wr_en <= 1'b0;
            if (start) begin
                // drops whatever a short previous packet left behind
                beat_cnt   <= '0;
                next_index <= start_index;
            end else if (last_beat) begin
                beat_cnt   <= '0;
                wr_en      <= 1'b1;
                next_index <= next_index + lookup_pkg::index_t'(1);
            end else if (beat_valid) begin
                beat_cnt <= beat_cnt + 4'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (beat_valid) begin
            acc_q <= acc_next;
        end
        if (last_beat) begin
            wr_entry <= entry_t'(acc_next[acc_width-1 -: entry_width]);
            wr_index <= next_index;
        end
    end

endmodule

`default_nettype wire

// File: verilog/lookup_ctrl.sv
// lookup sequencer, holds the phv and emits the hit action or the default action
`timescale 1ns/1ns
`default_nettype none

module lookup_ctrl (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                key_valid,
    input  lookup_pkg::phv_t    phv_in,
    input  logic                match,
    input  lookup_pkg::action_t rd_action,
    output lookup_pkg::action_t action,
    output logic                action_valid,
    output lookup_pkg::phv_t    phv_out
);

    typedef enum logic [1:0] {
        idle,
        check,
        wait_ram,
        emit
    } state_t;

    state_t              state;
    lookup_pkg::phv_t    phv_reg;
    lookup_pkg::action_t act_hold;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= idle;
            action_valid <= 1'b0;
        end else begin
            action_valid <= 1'b0;
            case (state)
                idle: begin
                    // keys arriving in any other state are dropped
                    if (key_valid) begin
                        state <= check;
                    end
                end
                check: begin
                    if (match) begin
                        state <= wait_ram;
                    end else begin
                        action_valid <= 1'b1;
                        state        <= idle;
                    end
                end
                wait_ram: begin
                    state <= emit;
                end
                default: begin
                    action_valid <= 1'b1;
                    state        <= idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == idle) && key_valid) begin
            phv_reg <= phv_in;
        end
        // match_addr tracks the live key, so the read for our key is only good now
        if (state == wait_ram) begin
            act_hold <= rd_action;
        end
        if ((state == check) && !match) begin
            action  <= lookup_pkg::default_action;
            phv_out <= phv_reg;
        end
        if (state == emit) begin
            action  <= act_hold;
            phv_out <= phv_reg;
        end
    end

    a_valid_single: assert property (
        @(posedge clk) disable iff (!rst_n)
        action_valid |=> !action_valid
    ) else $error("action_valid held for more than one cycle");

endmodule

`default_nettype wire

// File: verilog/lookup_engine.sv
// top of the lookup stage, connects control parsing, table loading, cam, action memory and sequencer
`timescale 1ns/1ns
`default_nettype none

module lookup_engine #(
    parameter logic [4:0] stage_id  = 5'd0,
    parameter logic [2:0] lookup_id = 3'd0
) (
    input  logic                 clk,
    input  logic                 rst_n,
    // lookup side
    input  lookup_pkg::key_t     key,
    input  lookup_pkg::key_t     mask,
    input  logic                 key_valid,
    input  lookup_pkg::phv_t     phv_in,
    output lookup_pkg::action_t  action,
    output logic                 action_valid,
    output lookup_pkg::phv_t     phv_out,
    // control stream, no back-pressure
    input  ctrl_pkg::ctrl_data_t c_s_tdata,
    input  logic                 c_s_tvalid,
    input  logic                 c_s_tlast,
    output ctrl_pkg::ctrl_data_t c_m_tdata,
    output logic                 c_m_tvalid,
    output logic                 c_m_tlast
);

    logic                 cam_start;
    logic                 act_start;
    lookup_pkg::index_t   start_index;
    logic                 cam_beat_valid;
    logic                 act_beat_valid;
    ctrl_pkg::ctrl_data_t beat_data;

    logic                 cam_wr_en;
    lookup_pkg::index_t   cam_wr_index;
    lookup_pkg::key_t     cam_wr_key;
    logic                 act_wr_en;
    lookup_pkg::index_t   act_wr_index;
    lookup_pkg::action_t  act_wr_entry;

    logic                 match;
    lookup_pkg::index_t   match_addr;
    lookup_pkg::action_t  rd_action;

    ctrl_parser #(
        .stage_id  (stage_id),
        .lookup_id (lookup_id)
    ) u_parser (
        .clk            (clk),
        .rst_n          (rst_n),
        .c_s_tdata      (c_s_tdata),
        .c_s_tvalid     (c_s_tvalid),
        .c_s_tlast      (c_s_tlast),
        .c_m_tdata      (c_m_tdata),
        .c_m_tvalid     (c_m_tvalid),
        .c_m_tlast      (c_m_tlast),
        .cam_start      (cam_start),
        .act_start      (act_start),
        .start_index    (start_index),
        .cam_beat_valid (cam_beat_valid),
        .act_beat_valid (act_beat_valid),
        .beat_data      (beat_data)
    );

    // one beat per key
    entry_assembler #(
        .entry_t (lookup_pkg::key_t)
    ) u_cam_asm (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (cam_start),
        .start_index (start_index),
        .beat_valid  (cam_beat_valid),
        .beat_data   (beat_data),
        .wr_en       (cam_wr_en),
        .wr_index    (cam_wr_index),
        .wr_entry    (cam_wr_key)
    );

    // two beats per action
    entry_assembler #(
        .entry_t (lookup_pkg::action_t)
    ) u_act_asm (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (act_start),
        .start_index (start_index),
        .beat_valid  (act_beat_valid),
        .beat_data   (beat_data),
        .wr_en       (act_wr_en),
        .wr_index    (act_wr_index),
        .wr_entry    (act_wr_entry)
    );

    match_cam u_cam (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr_en      (cam_wr_en),
        .wr_index   (cam_wr_index),
        .wr_key     (cam_wr_key),
        .key        (key),
        .mask       (mask),
        .match      (match),
        .match_addr (match_addr)
    );

    action_ram u_act_ram (
        .clk       (clk),
        .wr_en     (act_wr_en),
        .wr_index  (act_wr_index),
        .wr_action (act_wr_entry),
        .rd_index  (match_addr),
        .rd_action (rd_action)
    );

    lookup_ctrl u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .key_valid    (key_valid),
        .phv_in       (phv_in),
        .match        (match),
        .rd_action    (rd_action),
        .action       (action),
        .action_valid (action_valid),
        .phv_out      (phv_out)
    );

endmodule

`default_nettype wire

// File: verilog/lookup_pkg.sv
// lookup-side widths, table depth and payload types, referenced by scoped name from the RTL
`default_nettype none

package lookup_pkg;

    // lookup datapath widths
    localparam int key_width    = 24;
    localparam int action_width = 128;
    localparam int phv_width    = 64;

    // cam and action memory share one address space
    localparam int table_depth = 16;
    localparam int index_width = $clog2(table_depth);

    typedef logic [key_width-1:0]    key_t;
    typedef logic [action_width-1:0] action_t;
    typedef logic [phv_width-1:0]    phv_t;
    typedef logic [index_width-1:0]  index_t;

    // emitted on a miss
    localparam action_t default_action = action_t'(128'h3f);

endpackage

`default_nettype wire

// File: verilog/match_cam.sv
// masked cam with a single write port, compared every cycle with a registered priority result
`timescale 1ns/1ns
`default_nettype none

module match_cam (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               wr_en,
    input  lookup_pkg::index_t wr_index,
    input  lookup_pkg::key_t   wr_key,
    input  lookup_pkg::key_t   key,
    input  lookup_pkg::key_t   mask,
    output logic               match,
    output lookup_pkg::index_t match_addr
);

    lookup_pkg::key_t                  keys [lookup_pkg::table_depth];
    logic [lookup_pkg::table_depth-1:0] valid;
    logic [lookup_pkg::table_depth-1:0] hit_vec;
    lookup_pkg::index_t                hit_addr;

    // mask bit set means don't care
    always_comb begin
        for (int i = 0; i < lookup_pkg::table_depth; i++) begin
            hit_vec[i] = valid[i] && (((keys[i] ^ key) & ~mask) == '0);
        end
    end

    // walk downwards so the lowest index is the one left standing
    always_comb begin
        hit_addr = '0;
        for (int i = lookup_pkg::table_depth - 1; i >= 0; i--) begin
            if (hit_vec[i]) begin
                hit_addr = lookup_pkg::index_t'(i);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid      <= '0;
            match      <= 1'b0;
            match_addr <= '0;
        end else begin
            if (wr_en) begin
                valid[wr_index] <= 1'b1;
            end
            match      <= |hit_vec;
            match_addr <= hit_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            keys[wr_index] <= wr_key;
        end
    end

    a_match_valid: assert property (
        @(posedge clk) disable iff (!rst_n)
        match |-> valid[match_addr]
    ) else $error("cam match on an invalid entry");

endmodule

`default_nettype wire
